// File: rv32i_types_pkg.sv
package rv32i_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        reg_idx_t    rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        opcode_t    opcode;
    } j_fmt_t;

    // One fetched word, viewed in every encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_t;

endpackage

// File: core_ctrl_pkg.sv
package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic {
        OPA_RS1,
        OPA_PC
    } op_a_sel_t;

    typedef enum logic {
        OPB_RS2,
        OPB_IMM
    } op_b_sel_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4,
        WB_NONE
    } wb_sel_t;

    // Control word produced by decode
    typedef struct packed {
        rv32i_types_pkg::word_t    pc;
        rv32i_types_pkg::word_t    imm;
        rv32i_types_pkg::reg_idx_t rs1;
        rv32i_types_pkg::reg_idx_t rs2;
        rv32i_types_pkg::reg_idx_t rd;
        alu_op_t                   alu_op;
        op_a_sel_t                 op_a_sel;
        op_b_sel_t                 op_b_sel;
        wb_sel_t                   wb_sel;
        logic                      is_branch;
        logic                      is_jal;
        logic                      is_jalr;
        logic                      mem_read;
        logic                      mem_write;
        // Compare kind for branches, access width for loads and stores
        logic [2:0]                funct3;
    } decoded_t;

    typedef struct packed {
        logic                   valid;
        decoded_t               dec;
        rv32i_types_pkg::word_t rs1_val;
        rv32i_types_pkg::word_t rs2_val;
    } exec_t;

    typedef struct packed {
        logic                      we;
        rv32i_types_pkg::reg_idx_t rd;
        rv32i_types_pkg::word_t    data;
    } wb_t;

    typedef struct packed {
        logic                   valid;
        rv32i_types_pkg::word_t target;
    } redirect_t;

    typedef struct packed {
        rv32i_types_pkg::word_t addr;
        rv32i_types_pkg::word_t wdata;
        logic [3:0]             byte_en;
        logic                   we;
        logic                   re;
    } dmem_req_t;

endpackage

// File: inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder #(
    parameter rv32i_types_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                      clk,
    input  logic                      i_reset,
    input  rv32i_types_pkg::word_t    i_imem_rdata,
    input  core_ctrl_pkg::redirect_t  i_redirect,
    output rv32i_types_pkg::word_t    o_imem_addr,
    output core_ctrl_pkg::decoded_t   o_dec
);
    import rv32i_types_pkg::*;
    import core_ctrl_pkg::*;

    instr_t  instr;
    opcode_t opcode;
    word_t   pc;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;
    alu_op_t arith_op;

    assign instr       = i_imem_rdata;
    assign opcode      = instr.r_fmt.opcode;
    assign o_imem_addr = pc;

    // PC steps by 4 unless execute resolves a taken branch or jump
    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc <= RESET_PC;
        end else if (i_redirect.valid) begin
            pc <= i_redirect.target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // Immediates, sign extended from bit 31
    assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign imm_b = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                    instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
    assign imm_u = {instr.u_fmt.imm31_12, 12'h000};
    assign imm_j = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                    instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};

    // funct7 bit 5 picks SUB and SRA; for OP_IMM it is imm bit 10
    always_comb begin
        unique case (instr.r_fmt.funct3)
            3'b000: arith_op = (opcode == OPC_OP && instr.r_fmt.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001: arith_op = ALU_SLL;
            3'b010: arith_op = ALU_SLT;
            3'b011: arith_op = ALU_SLTU;
            3'b100: arith_op = ALU_XOR;
            3'b101: arith_op = instr.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110: arith_op = ALU_OR;
            3'b111: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        o_dec.pc        = pc;
        o_dec.imm       = imm_i;
        o_dec.rs1       = instr.r_fmt.rs1;
        o_dec.rs2       = instr.r_fmt.rs2;
        o_dec.rd        = instr.r_fmt.rd;
        o_dec.funct3    = instr.r_fmt.funct3;
        o_dec.alu_op    = ALU_ADD;
        o_dec.op_a_sel  = OPA_RS1;
        o_dec.op_b_sel  = OPB_IMM;
        o_dec.wb_sel    = WB_NONE;
        o_dec.is_branch = 1'b0;
        o_dec.is_jal    = 1'b0;
        o_dec.is_jalr   = 1'b0;
        o_dec.mem_read  = 1'b0;
        o_dec.mem_write = 1'b0;

        unique case (opcode)
            OPC_OP: begin
                o_dec.alu_op   = arith_op;
                o_dec.op_b_sel = OPB_RS2;
                o_dec.wb_sel   = WB_ALU;
            end
            OPC_OP_IMM: begin
                o_dec.alu_op = arith_op;
                o_dec.wb_sel = WB_ALU;
            end
            OPC_LUI: begin
                // x0 plus the upper immediate
                o_dec.imm    = imm_u;
                o_dec.rs1    = '0;
                o_dec.wb_sel = WB_ALU;
            end
            OPC_AUIPC: begin
                o_dec.imm      = imm_u;
                o_dec.op_a_sel = OPA_PC;
                o_dec.wb_sel   = WB_ALU;
            end
            OPC_JAL: begin
                o_dec.imm    = imm_j;
                o_dec.is_jal = 1'b1;
                o_dec.wb_sel = WB_PC4;
            end
            OPC_JALR: begin
                o_dec.is_jalr = 1'b1;
                o_dec.wb_sel  = WB_PC4;
            end
            OPC_BRANCH: begin
                o_dec.imm       = imm_b;
                o_dec.is_branch = 1'b1;
            end
            OPC_LOAD: begin
                o_dec.mem_read = 1'b1;
                o_dec.wb_sel   = WB_LOAD;
            end
            OPC_STORE: begin
                o_dec.imm       = imm_s;
                o_dec.mem_write = 1'b1;
            end
            default: begin
                // Unsupported word decodes as a no-op
                o_dec.wb_sel = WB_NONE;
            end
        endcase
    end

    // Wrong-path fetch during a redirect is discarded downstream
    a_opcode_supported: assert property (@(posedge clk) disable iff (i_reset)
        !i_redirect.valid |-> opcode inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                                             OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
                                             OPC_STORE})
        else $fatal(1, "%0t Unsupported opcode %b at pc %h", $time, opcode, pc);

endmodule

// File: operand_stage.sv
`timescale 1ns/10ps

module operand_stage (
    input  logic                     clk,
    input  logic                     i_reset,
    input  core_ctrl_pkg::decoded_t  i_dec,
    input  core_ctrl_pkg::wb_t       i_wb,
    input  core_ctrl_pkg::redirect_t i_redirect,
    output core_ctrl_pkg::exec_t     o_exec
);
    import rv32i_types_pkg::*;
    import core_ctrl_pkg::*;

    // x0 has no storage
    word_t regs [31:1];
    word_t rs1_val;
    word_t rs2_val;

    // Writeback of the instruction in execute is visible in the same cycle
    function automatic word_t read_operand(input reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (i_wb.we && i_wb.rd == idx) begin
            val = i_wb.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.we && i_wb.rd != '0) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    always_comb begin
        rs1_val = read_operand(i_dec.rs1);
        rs2_val = read_operand(i_dec.rs2);
    end

    // Decode-to-execute register
    always_ff @(posedge clk) begin
        o_exec.dec     <= i_dec;
        o_exec.rs1_val <= rs1_val;
        o_exec.rs2_val <= rs2_val;
        // Wrong-path instruction becomes a bubble
        if (i_reset || i_redirect.valid) begin
            o_exec.valid <= 1'b0;
        end else begin
            o_exec.valid <= 1'b1;
        end
    end

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (i_reset)
        (o_exec.valid && o_exec.dec.rs1 == '0) |-> (o_exec.rs1_val == '0))
        else $fatal(1, "%0t Nonzero value carried for rs1 = x0", $time);

endmodule

// File: execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  core_ctrl_pkg::exec_t      i_exec,
    input  rv32i_types_pkg::word_t    i_dmem_rdata,
    output core_ctrl_pkg::dmem_req_t  o_dmem,
    output core_ctrl_pkg::wb_t        o_wb,
    output core_ctrl_pkg::redirect_t  o_redirect
);
    import rv32i_types_pkg::*;
    import core_ctrl_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      alu_res;
    word_t      pc_plus4;
    word_t      load_word;
    word_t      load_val;
    logic [1:0] lane;
    logic       br_eq;
    logic       br_lt;
    logic       br_ltu;
    logic       taken;

    always_comb begin
        unique case (i_exec.dec.op_a_sel)
            OPA_RS1: op_a = i_exec.rs1_val;
            OPA_PC:  op_a = i_exec.dec.pc;
        endcase
        unique case (i_exec.dec.op_b_sel)
            OPB_RS2: op_b = i_exec.rs2_val;
            OPB_IMM: op_b = i_exec.dec.imm;
        endcase
    end

    always_comb begin
        unique case (i_exec.dec.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = '0;
        endcase
    end

    // Branch compare always on rs1 and rs2
    assign br_eq  = (i_exec.rs1_val == i_exec.rs2_val);
    assign br_lt  = ($signed(i_exec.rs1_val) < $signed(i_exec.rs2_val));
    assign br_ltu = (i_exec.rs1_val < i_exec.rs2_val);

    always_comb begin
        unique case (i_exec.dec.funct3)
            3'b000:  taken = br_eq;
            3'b001:  taken = !br_eq;
            3'b100:  taken = br_lt;
            3'b101:  taken = !br_lt;
            3'b110:  taken = br_ltu;
            3'b111:  taken = !br_ltu;
            default: taken = 1'b0;
        endcase
    end

    assign o_redirect.valid = i_exec.valid &&
                              ((i_exec.dec.is_branch && taken) ||
                               i_exec.dec.is_jal || i_exec.dec.is_jalr);
    // JALR target comes through the ALU sum with bit 0 dropped
    assign o_redirect.target = i_exec.dec.is_jalr ? {alu_res[31:1], 1'b0}
                                                  : i_exec.dec.pc + i_exec.dec.imm;

    // Data memory sees the word address, lane picked by the low bits
    assign lane          = alu_res[1:0];
    assign o_dmem.addr   = {alu_res[31:2], 2'b00};
    assign o_dmem.we     = i_exec.valid && i_exec.dec.mem_write;
    assign o_dmem.re     = i_exec.valid && i_exec.dec.mem_read;
    assign o_dmem.wdata  = i_exec.rs2_val << {lane, 3'b000};

    always_comb begin
        unique case (i_exec.dec.funct3[1:0])
            2'b00:   o_dmem.byte_en = 4'b0001 << lane;
            2'b01:   o_dmem.byte_en = 4'b0011 << {lane[1], 1'b0};
            default: o_dmem.byte_en = 4'b1111;
        endcase
    end

    assign load_word = i_dmem_rdata >> {lane, 3'b000};

    always_comb begin
        unique case (i_exec.dec.funct3)
            3'b000:  load_val = {{24{load_word[7]}}, load_word[7:0]};
            3'b001:  load_val = {{16{load_word[15]}}, load_word[15:0]};
            3'b100:  load_val = {24'b0, load_word[7:0]};
            3'b101:  load_val = {16'b0, load_word[15:0]};
            default: load_val = load_word;
        endcase
    end

    assign pc_plus4 = i_exec.dec.pc + 32'd4;

    assign o_wb.we = i_exec.valid && (i_exec.dec.wb_sel != WB_NONE);
    assign o_wb.rd = i_exec.dec.rd;

    always_comb begin
        unique case (i_exec.dec.wb_sel)
            WB_ALU:  o_wb.data = alu_res;
            WB_LOAD: o_wb.data = load_val;
            WB_PC4:  o_wb.data = pc_plus4;
            WB_NONE: o_wb.data = alu_res;
        endcase
    end

    // No clock here, so these are checked once the cycle settles
    a_no_read_write: assert final (!(o_dmem.we === 1'b1 && o_dmem.re === 1'b1))
        else $fatal(1, "%0t Data memory read and write in one cycle", $time);

    a_target_aligned: assert final (o_redirect.valid !== 1'b1 ||
                                    o_redirect.target[1:0] === 2'b00)
        else $fatal(1, "%0t Misaligned jump target %h", $time, o_redirect.target);

endmodule

// File: rv32i_core.sv
`timescale 1ns/10ps

module rv32i_core #(
    parameter rv32i_types_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                     clk,
    input  logic                     i_reset,
    output rv32i_types_pkg::word_t   o_imem_addr,
    input  rv32i_types_pkg::word_t   i_imem_rdata,
    output core_ctrl_pkg::dmem_req_t o_dmem,
    input  rv32i_types_pkg::word_t   i_dmem_rdata
);
    import core_ctrl_pkg::*;

    decoded_t  dec;
    exec_t     exec;
    wb_t       wb;
    redirect_t redirect;

    inst_decoder #(
        .RESET_PC(RESET_PC)
    ) i_inst_decoder (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_imem_rdata (i_imem_rdata),
        .i_redirect   (redirect),
        .o_imem_addr  (o_imem_addr),
        .o_dec        (dec)
    );

    operand_stage i_operand_stage (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_dec      (dec),
        .i_wb       (wb),
        .i_redirect (redirect),
        .o_exec     (exec)
    );

    execute_stage i_execute_stage (
        .i_exec       (exec),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem       (o_dmem),
        .o_wb         (wb),
        .o_redirect   (redirect)
    );

endmodule

// File: tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam logic [6:0] OP_REG   = 7'b0110011;
localparam logic [6:0] OP_IMM   = 7'b0010011;
localparam logic [6:0] OP_LUI   = 7'b0110111;
localparam logic [6:0] OP_AUIPC = 7'b0010111;
localparam logic [6:0] OP_JAL   = 7'b1101111;
localparam logic [6:0] OP_JALR  = 7'b1100111;
localparam logic [6:0] OP_BR    = 7'b1100011;
localparam logic [6:0] OP_LOAD  = 7'b0000011;
localparam logic [6:0] OP_STORE = 7'b0100011;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

// Offset bit 0 is dropped by the format
function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BR};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] rand_word();
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < 32; i++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        val = {val[30:0], fb};
    end
    return val;
endfunction

function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic ref_taken(input logic [2:0] f3, input logic [31:0] a,
                                   input logic [31:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic logic [31:0] ref_load(input logic [2:0] f3, input logic [31:0] w,
                                         input logic [1:0] off);
    logic [31:0] sh;
    sh = w >> (8 * off);
    case (f3)
        3'd0: return {{24{sh[7]}}, sh[7:0]};
        3'd1: return {{16{sh[15]}}, sh[15:0]};
        3'd4: return {24'b0, sh[7:0]};
        3'd5: return {16'b0, sh[15:0]};
        default: return w;
    endcase
endfunction

function automatic logic [31:0] ref_store(input logic [2:0] f3, input logic [31:0] old,
                                          input logic [31:0] d, input logic [1:0] off);
    logic [31:0] mask;
    mask = (f3 == 3'd0) ? 32'h0000_00ff : (f3 == 3'd1) ? 32'h0000_ffff : 32'hffff_ffff;
    mask = mask << (8 * off);
    return (old & ~mask) | ((d << (8 * off)) & mask);
endfunction

`endif

// File: tb_rv32i_core.sv
`timescale 1ns/10ps

module tb_rv32i_core;

    localparam logic [3:0] K_OP    = 4'd0;
    localparam logic [3:0] K_IMM   = 4'd1;
    localparam logic [3:0] K_LUI   = 4'd2;
    localparam logic [3:0] K_AUIPC = 4'd3;
    localparam logic [3:0] K_BR    = 4'd4;
    localparam logic [3:0] K_JAL   = 4'd5;
    localparam logic [3:0] K_JALR  = 4'd6;
    localparam logic [3:0] K_LOAD  = 4'd7;
    localparam logic [3:0] K_STORE = 4'd8;

    // alt sets funct7 bit 5 for ALU kinds and gives equal operands for branches
    typedef struct packed {
        logic [3:0] kind;
        logic [2:0] f3;
        logic       alt;
        logic [1:0] off;
    } test_t;

    localparam int N_TESTS  = 55;
    localparam int PROG_MAX = 12;
    localparam int TIMEOUT  = N_TESTS * (PROG_MAX + 5 + 10);

    localparam test_t TESTS [0:N_TESTS-1] = '{
        '{K_OP, 3'd0, 1'b0, 2'd0}, '{K_OP, 3'd0, 1'b1, 2'd0}, '{K_OP, 3'd1, 1'b0, 2'd0},
        '{K_OP, 3'd2, 1'b0, 2'd0}, '{K_OP, 3'd3, 1'b0, 2'd0}, '{K_OP, 3'd4, 1'b0, 2'd0},
        '{K_OP, 3'd5, 1'b0, 2'd0}, '{K_OP, 3'd5, 1'b1, 2'd0}, '{K_OP, 3'd6, 1'b0, 2'd0},
        '{K_OP, 3'd7, 1'b0, 2'd0},
        '{K_IMM, 3'd0, 1'b0, 2'd0}, '{K_IMM, 3'd1, 1'b0, 2'd0}, '{K_IMM, 3'd2, 1'b0, 2'd0},
        '{K_IMM, 3'd3, 1'b0, 2'd0}, '{K_IMM, 3'd4, 1'b0, 2'd0}, '{K_IMM, 3'd5, 1'b0, 2'd0},
        '{K_IMM, 3'd5, 1'b1, 2'd0}, '{K_IMM, 3'd6, 1'b0, 2'd0}, '{K_IMM, 3'd7, 1'b0, 2'd0},
        '{K_LUI, 3'd0, 1'b0, 2'd0}, '{K_AUIPC, 3'd0, 1'b0, 2'd0},
        '{K_BR, 3'd0, 1'b0, 2'd0}, '{K_BR, 3'd0, 1'b1, 2'd0}, '{K_BR, 3'd1, 1'b0, 2'd0},
        '{K_BR, 3'd1, 1'b1, 2'd0}, '{K_BR, 3'd4, 1'b0, 2'd0}, '{K_BR, 3'd4, 1'b1, 2'd0},
        '{K_BR, 3'd5, 1'b0, 2'd0}, '{K_BR, 3'd5, 1'b1, 2'd0}, '{K_BR, 3'd6, 1'b0, 2'd0},
        '{K_BR, 3'd6, 1'b1, 2'd0}, '{K_BR, 3'd7, 1'b0, 2'd0}, '{K_BR, 3'd7, 1'b1, 2'd0},
        '{K_JAL, 3'd0, 1'b0, 2'd0}, '{K_JALR, 3'd0, 1'b0, 2'd0},
        '{K_LOAD, 3'd0, 1'b0, 2'd0}, '{K_LOAD, 3'd0, 1'b0, 2'd1}, '{K_LOAD, 3'd0, 1'b0, 2'd2},
        '{K_LOAD, 3'd0, 1'b0, 2'd3}, '{K_LOAD, 3'd4, 1'b0, 2'd0}, '{K_LOAD, 3'd4, 1'b0, 2'd1},
        '{K_LOAD, 3'd4, 1'b0, 2'd2}, '{K_LOAD, 3'd4, 1'b0, 2'd3}, '{K_LOAD, 3'd1, 1'b0, 2'd0},
        '{K_LOAD, 3'd1, 1'b0, 2'd2}, '{K_LOAD, 3'd5, 1'b0, 2'd0}, '{K_LOAD, 3'd5, 1'b0, 2'd2},
        '{K_LOAD, 3'd2, 1'b0, 2'd0},
        '{K_STORE, 3'd0, 1'b0, 2'd0}, '{K_STORE, 3'd0, 1'b0, 2'd1},
        '{K_STORE, 3'd0, 1'b0, 2'd2}, '{K_STORE, 3'd0, 1'b0, 2'd3},
        '{K_STORE, 3'd1, 1'b0, 2'd0}, '{K_STORE, 3'd1, 1'b0, 2'd2},
        '{K_STORE, 3'd2, 1'b0, 2'd0}
    };

    logic                     clk;
    logic                     i_reset;
    logic [31:0]              imem_addr;
    logic [31:0]              imem_rdata;
    core_ctrl_pkg::dmem_req_t dmem;
    logic [31:0]              dmem_rdata;

    logic [31:0] imem     [0:255];
    logic [31:0] dmem_mem [0:1023];
    logic [31:0] init_mem [0:1023];
    logic [31:0] exp_mem  [0:1023];
    logic [31:0] lfsr_state = 32'h54b1b52c;
    int          prog_len;
    int          cycles = 0;

    `include "tb_programs.svh"

    rv32i_core #(
        .RESET_PC(32'h0000_0000)
    ) i_rv32i_core (
        .clk          (clk),
        .i_reset      (i_reset),
        .o_imem_addr  (imem_addr),
        .i_imem_rdata (imem_rdata),
        .o_dmem       (dmem),
        .i_dmem_rdata (dmem_rdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem_mem[dmem.addr[11:2]];

    // Reset reloads the data memory image
    always @(posedge clk) begin
        if (i_reset) begin
            for (int k = 0; k < 1024; k++) begin
                dmem_mem[k] <= init_mem[k];
            end
        end else if (dmem.we === 1'b1) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem.byte_en[b]) begin
                    dmem_mem[dmem.addr[11:2]][b*8 +: 8] <= dmem.wdata[b*8 +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: a program never reached its end store after %0d cycles", cycles);
            $display("Checks failed");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic emit(input logic [31:0] instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    // LUI then ADDI with the upper part rounded for the signed low part
    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = (v + 32'h800) >> 12;
        emit(enc_u(hi[19:0], rd, OP_LUI));
        emit(enc_i(v[11:0], rd, 3'd0, rd, OP_IMM));
    endtask

    task automatic build_program(input test_t t, input logic [31:0] a, input logic [31:0] b);
        logic [11:0] imm;
        logic        taken;
        prog_len = 0;
        load_const(5'd1, a);
        load_const(5'd2, b);
        // Instruction under test sits at pc 0x10
        case (t.kind)
            K_OP: begin
                emit(enc_r({1'b0, t.alt, 5'b0}, 5'd2, 5'd1, t.f3, 5'd3));
                emit(enc_s(12'h100, 5'd3, 5'd0, 3'd2));
                exp_mem[64] = ref_alu(t.f3, t.alt, a, b);
            end
            K_IMM: begin
                imm = (t.f3 == 3'd1 || t.f3 == 3'd5) ? {1'b0, t.alt, 5'b0, b[4:0]} : b[11:0];
                emit(enc_i(imm, 5'd1, t.f3, 5'd3, OP_IMM));
                emit(enc_s(12'h100, 5'd3, 5'd0, 3'd2));
                exp_mem[64] = ref_alu(t.f3, t.alt, a, {{20{imm[11]}}, imm});
            end
            K_LUI, K_AUIPC: begin
                emit(enc_u(a[31:12], 5'd3, (t.kind == K_LUI) ? OP_LUI : OP_AUIPC));
                emit(enc_s(12'h100, 5'd3, 5'd0, 3'd2));
                exp_mem[64] = {a[31:12], 12'h000} + ((t.kind == K_LUI) ? 32'h0 : 32'h10);
            end
            K_BR: begin
                // Poison store right behind the branch
                emit(enc_b(13'd12, 5'd2, 5'd1, t.f3));
                emit(enc_s(12'h104, 5'd1, 5'd0, 3'd2));
                emit(enc_i(12'd1, 5'd0, 3'd0, 5'd3, OP_IMM));
                emit(enc_s(12'h100, 5'd3, 5'd0, 3'd2));
                taken = ref_taken(t.f3, a, b);
                exp_mem[64] = taken ? 32'h0 : 32'h1;
                if (!taken) begin
                    exp_mem[65] = a;
                end
            end
            K_JAL: begin
                emit(enc_j(21'd12, 5'd3));
                emit(enc_s(12'h104, 5'd1, 5'd0, 3'd2));
                emit(enc_s(12'h104, 5'd1, 5'd0, 3'd2));
                emit(enc_s(12'h100, 5'd3, 5'd0, 3'd2));
                exp_mem[64] = 32'h14;
            end
            K_JALR: begin
                // Odd base address that JALR rounds down to 0x24
                emit(enc_i(12'h025, 5'd0, 3'd0, 5'd1, OP_IMM));
                emit(enc_i(12'h000, 5'd1, 3'd0, 5'd3, OP_JALR));
                emit(enc_s(12'h104, 5'd1, 5'd0, 3'd2));
                emit(enc_s(12'h104, 5'd1, 5'd0, 3'd2));
                emit(enc_s(12'h104, 5'd1, 5'd0, 3'd2));
                emit(enc_s(12'h100, 5'd3, 5'd0, 3'd2));
                exp_mem[64] = 32'h18;
            end
            K_LOAD: begin
                emit(enc_i(12'h200 + t.off, 5'd0, t.f3, 5'd3, OP_LOAD));
                emit(enc_s(12'h100, 5'd3, 5'd0, 3'd2));
                exp_mem[64] = ref_load(t.f3, exp_mem[128], t.off);
            end
            default: begin
                emit(enc_s(12'h200 + t.off, 5'd1, 5'd0, t.f3));
                exp_mem[128] = ref_store(t.f3, exp_mem[128], a, t.off);
            end
        endcase
        // End marker at 0xFFC
        emit(enc_s(12'hffc, 5'd0, 5'd0, 3'd2));
        exp_mem[1023] = 32'h0;
    endtask

    task automatic run_test(input test_t t);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] key;
        logic [31:0] tmp;
        int          reads;
        int          writes;
        int          exp_writes;
        a   = rand_word();
        b   = (t.kind == K_BR && t.alt) ? a : rand_word();
        key = rand_word();
        // Unequal branch operands go in rising order
        if (t.kind == K_BR && !t.alt &&
            (t.f3[1] ? (a > b) : ($signed(a) > $signed(b)))) begin
            tmp = a;
            a   = b;
            b   = tmp;
        end
        // Only a not-taken branch lets its poison store through
        exp_writes = (t.kind == K_BR && !ref_taken(t.f3, a, b)) ? 2 : 1;
        @(posedge clk);
        i_reset <= 1'b1;
        @(negedge clk);
        // Spare fetches decode as ADDI x0 with an address-dependent immediate
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_i({4'h0, i[7:0]}, 5'd0, 3'd0, 5'd0, OP_IMM);
        end
        for (int i = 0; i < 1024; i++) begin
            init_mem[i] = ({22'b0, i[9:0]} * 32'h9e37_79b1) ^ key;
            exp_mem[i]  = init_mem[i];
        end
        build_program(t, a, b);
        repeat (5) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        check_value("o_imem_addr", imem_addr, 32'h0);
        reads  = 0;
        writes = 0;
        while (!(dmem.we === 1'b1 && dmem.addr === 32'hffff_fffc)) begin
            check_value("o_imem_addr[1:0]", imem_addr[1:0], 32'h0);
            if (dmem.re === 1'b1) begin
                reads++;
            end
            if (dmem.we === 1'b1) begin
                writes++;
            end
            @(negedge clk);
        end
        @(posedge clk);
        @(negedge clk);
        check_value("o_dmem.re cycles", reads, (t.kind == K_LOAD) ? 32'd1 : 32'd0);
        check_value("o_dmem.we cycles", writes, exp_writes);
        for (int i = 0; i < 1024; i++) begin
            check_value($sformatf("dmem[%h]", i * 4), dmem_mem[i], exp_mem[i]);
        end
    endtask

    initial begin
        i_reset = 1'b1;
        for (int n = 0; n < N_TESTS; n++) begin
            run_test(TESTS[n]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// File: project.f
+incdir+.
rv32i_types_pkg.sv
core_ctrl_pkg.sv
inst_decoder.sv
operand_stage.sv
execute_stage.sv
rv32i_core.sv
tb_rv32i_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_rv32i_core

./obj_dir/Vtb_rv32i_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0
